//--- core_mem.f
+incdir+include
logic/core_mem_pkg.sv
logic/axi_read_arbiter.sv
logic/axi_write_buffer.sv
logic/perf_counters.sv
logic/core_mem_top.sv
test/core_mem_checker.sv
test/core_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds core_mem_tb with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f core_mem.f --top-module core_mem_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vcore_mem_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
exit 1

//--- test/core_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_mem_defines.svh"

module core_mem_tb;
  import core_mem_pkg::*;

  localparam int N_TESTS     = 6;
  localparam int WATCHDOG_NS = N_TESTS * 200 * 20 + 200;

  logic aclk;
  logic arst_n;
  logic inst_rd_valid, inst_rd_ready, inst_ret_valid;
  logic data_rd_valid, data_rd_ready, data_ret_valid;
  logic data_wr_valid, data_wr_ready;
  rd_req_t inst_rd_req, data_rd_req;
  rd_ret_t inst_ret, data_ret;
  wr_req_t data_wr_req;
  axi_id_t arid, awid, rid;
  addr_t araddr, awaddr;
  axi_len_t arlen, awlen;
  logic [2:0] arsize, awsize;
  logic [1:0] arburst, awburst;
  logic arvalid, arready, rlast, rvalid, rready;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  data_t rdata, wdata;
  strb_t wstrb;
  perf_cnt_t inst_reads, data_reads, data_writes, unc_stalls;

  // slave model state
  data_t mem [addr_t];
  addr_t rd_addr, aw_addr;
  data_t w_data;
  strb_t w_strb;
  axi_id_t rd_id;
  int rd_left;
  logic aw_got, w_got, b_pend, aw_stall, ar_stall;
  time ar_time, b_time;
  axi_id_t ar_id_q[$];
  addr_t ar_addr_q[$];
  axi_len_t ar_len_q[$];
  logic [4:0] ar_attr_q[$];
  logic [16:0] aw_attr_q[$];
  logic wlast_q[$];
  wr_req_t wlog[$];
  rd_ret_t inst_q[$], data_q[$];
  int inst_hs, data_hs, wr_hs, errors;
  integer seed;

  core_mem_top UUT (
    .aclk(aclk), .arst_n_i(arst_n),
    .inst_rd_valid_i(inst_rd_valid), .inst_rd_req_i(inst_rd_req),
    .inst_rd_ready_o(inst_rd_ready), .inst_ret_valid_o(inst_ret_valid), .inst_ret_o(inst_ret),
    .data_rd_valid_i(data_rd_valid), .data_rd_req_i(data_rd_req),
    .data_rd_ready_o(data_rd_ready), .data_ret_valid_o(data_ret_valid), .data_ret_o(data_ret),
    .data_wr_valid_i(data_wr_valid), .data_wr_req_i(data_wr_req),
    .data_wr_ready_o(data_wr_ready),
    .arid_o(arid), .araddr_o(araddr), .arlen_o(arlen), .arsize_o(arsize),
    .arburst_o(arburst), .arvalid_o(arvalid), .arready_i(arready),
    .rid_i(rid), .rdata_i(rdata), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready),
    .awid_o(awid), .awaddr_o(awaddr), .awlen_o(awlen), .awsize_o(awsize),
    .awburst_o(awburst), .awvalid_o(awvalid), .awready_i(awready),
    .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast), .wvalid_o(wvalid),
    .wready_i(wready), .bvalid_i(bvalid), .bready_o(bready),
    .inst_reads_o(inst_reads), .data_reads_o(data_reads),
    .data_writes_o(data_writes), .unc_stalls_o(unc_stalls)
  );

  always #10 aclk = ~aclk;

  // untouched words read back as a hash of the full address
  function automatic data_t word_at(input addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return (a * 32'h9e3779b1) ^ 32'hc0de0000;
  endfunction

  // byte lanes not enabled keep the old word
  function automatic data_t merge_bytes(input data_t old, input data_t d, input strb_t s);
    data_t r;
    r = old;
    for (int b = 0; b < `CORE_MEM_STRB_W; b++) begin
      if (s[b]) r[8*b +: 8] = d[8*b +: 8];
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // monitors and slave decisions sampled before the edge updates
  always @(posedge aclk) begin
    if (inst_rd_valid && inst_rd_ready) inst_hs++;
    if (data_rd_valid && data_rd_ready) data_hs++;
    if (data_wr_valid && data_wr_ready) wr_hs++;
    if (inst_ret_valid) inst_q.push_back(inst_ret);
    if (data_ret_valid) data_q.push_back(data_ret);
    if (rvalid && rready) begin
      rd_left--;
      rd_addr += 4;
    end
    if (arvalid && arready) begin
      ar_id_q.push_back(arid);
      ar_addr_q.push_back(araddr);
      ar_len_q.push_back(arlen);
      ar_attr_q.push_back({arsize, arburst});
      ar_time = $time;
      rd_addr = araddr;
      rd_id   = arid;
      rd_left = int'(arlen) + 1;
    end
    if (bvalid && bready) begin
      b_pend = 1'b0;
      b_time = $time;
    end
    if (awvalid && awready) begin
      aw_got  = 1'b1;
      aw_addr = awaddr;
      aw_attr_q.push_back({awid, awlen, awsize, awburst});
    end
    if (wvalid && wready) begin
      w_got  = 1'b1;
      w_data = wdata;
      w_strb = wstrb;
      wlast_q.push_back(wlast);
    end
    if (aw_got && w_got && !b_pend) begin
      mem[aw_addr] = merge_bytes(word_at(aw_addr), w_data, w_strb);
      wlog.push_back('{addr: aw_addr, data: w_data, strb: w_strb});
      b_pend = 1'b1;
      aw_got = 1'b0;
      w_got  = 1'b0;
    end
  end

  always @(negedge aclk) begin
    rvalid  <= (rd_left != 0);
    rdata   <= word_at(rd_addr);
    rlast   <= (rd_left == 1);
    rid     <= rd_id;
    bvalid  <= b_pend;
    awready <= !aw_stall;
    arready <= !ar_stall;
  end

  task automatic request_reads(input logic do_inst, input logic do_data,
                               input rd_req_t ireq, input rd_req_t dreq);
    logic i_pend;
    logic d_pend;
    @(negedge aclk);
    i_pend = do_inst;
    d_pend = do_data;
    inst_rd_req   = ireq;
    data_rd_req   = dreq;
    inst_rd_valid = i_pend;
    data_rd_valid = d_pend;
    while (i_pend || d_pend) begin
      @(posedge aclk);
      if (inst_rd_valid && inst_rd_ready) i_pend = 1'b0;
      if (data_rd_valid && data_rd_ready) d_pend = 1'b0;
      @(negedge aclk);
      inst_rd_valid = i_pend;
      data_rd_valid = d_pend;
    end
  endtask

  task automatic write_word(input addr_t a, input data_t d);
    @(negedge aclk);
    data_wr_req   = '{addr: a, data: d, strb: 4'hf};
    data_wr_valid = 1'b1;
    do @(posedge aclk); while (!data_wr_ready);
    @(negedge aclk);
    data_wr_valid = 1'b0;
  endtask

  task automatic wait_beats(input int n_inst, input int n_data);
    while (inst_q.size() < n_inst || data_q.size() < n_data) @(posedge aclk);
    // a stray extra beat would show up here
    repeat (3) @(posedge aclk);
    check("inst beats", inst_q.size(), n_inst);
    check("data beats", data_q.size(), n_data);
  endtask

  task automatic check_line(input addr_t base, input int beats, input logic on_data);
    rd_ret_t r;
    for (int i = 0; i < beats; i++) begin
      r = on_data ? data_q[i] : inst_q[i];
      check("ret.data", r.data, word_at(base + 4 * i));
      check("ret.last", r.last, (i == beats - 1));
    end
  endtask

  task automatic clear_logs();
    inst_q.delete();
    data_q.delete();
    ar_id_q.delete();
    ar_addr_q.delete();
    ar_len_q.delete();
    ar_attr_q.delete();
    aw_attr_q.delete();
    wlast_q.delete();
    wlog.delete();
  endtask

  task automatic read_cached_line();
    addr_t a;
    clear_logs();
    a = 32'h1000_0000 | ($random(seed) & 32'h000f_fffc);
    ar_stall = 1'b1;
    request_reads(1'b1, 1'b0, '{addr: a, uncached: 1'b0}, '0);
    // arvalid waits on arready and no other read is taken meanwhile
    repeat (3) begin
      @(negedge aclk);
      check("arvalid", arvalid, 1);
      check("inst_rd_ready", inst_rd_ready, 0);
      check("data_rd_ready", data_rd_ready, 0);
    end
    ar_stall = 1'b0;
    wait_beats(4, 0);
    check("arid", ar_id_q[0], `CORE_MEM_INST_ID);
    check("arlen", ar_len_q[0], 3);
    check("arsize/arburst", ar_attr_q[0], {3'd2, 2'b01});
    check("araddr", ar_addr_q[0], a & ~32'hf);
    check_line(a & ~32'hf, 4, 1'b0);
  endtask

  task automatic read_uncached_word();
    addr_t a;
    clear_logs();
    a = 32'h2000_0000 | ($random(seed) & 32'h000f_fffc);
    request_reads(1'b0, 1'b1, '0, '{addr: a, uncached: 1'b1});
    wait_beats(0, 1);
    check("arlen", ar_len_q[0], 0);
    check("araddr", ar_addr_q[0], a);
    check_line(a, 1, 1'b1);
  endtask

  task automatic write_then_read_back();
    addr_t a;
    data_t v;
    clear_logs();
    a = 32'h3000_0000 | ($random(seed) & 32'h000f_fffc);
    v = $random(seed);
    write_word(a, v);
    request_reads(1'b0, 1'b1, '0, '{addr: a, uncached: 1'b1});
    wait_beats(0, 1);
    check("AR after B", (ar_time > b_time), 1);
    check("data_ret.data", data_q[0].data, v);
    check("unc_stalls nonzero", (unc_stalls != 0), 1);
  endtask

  task automatic fill_write_buffer();
    wr_req_t sent [`CORE_MEM_WBUF_DEPTH + 1];
    int accepted;
    clear_logs();
    aw_stall = 1'b1;
    accepted = 0;
    for (int i = 0; i <= `CORE_MEM_WBUF_DEPTH; i++) begin
      sent[i] = '{addr: 32'h4000_0000 + 4 * i, data: $random(seed),
                  strb: strb_t'($random(seed))};
    end
    @(negedge aclk);
    data_wr_req   = sent[0];
    data_wr_valid = 1'b1;
    forever begin
      @(posedge aclk);
      if (!data_wr_ready || accepted > `CORE_MEM_WBUF_DEPTH) break;
      accepted++;
      @(negedge aclk);
      data_wr_req = sent[accepted];
    end
    @(negedge aclk);
    data_wr_valid = 1'b0;
    check("writes accepted", accepted, `CORE_MEM_WBUF_DEPTH);
    check("data_wr_ready", data_wr_ready, 0);
    aw_stall = 1'b0;
    while (wlog.size() < `CORE_MEM_WBUF_DEPTH) @(posedge aclk);
    for (int i = 0; i < `CORE_MEM_WBUF_DEPTH; i++) begin
      check("awaddr", wlog[i].addr, sent[i].addr);
      check("wdata", wlog[i].data, sent[i].data);
      check("wstrb", wlog[i].strb, sent[i].strb);
      check("awid/awlen/awsize/awburst", aw_attr_q[i],
            {axi_id_t'(`CORE_MEM_DATA_ID), 8'd0, 3'd2, 2'b01});
      check("wlast", wlast_q[i], 1);
    end
  endtask

  task automatic read_priority_order();
    clear_logs();
    request_reads(1'b1, 1'b1, '{addr: 32'h5000_0040, uncached: 1'b0},
                  '{addr: 32'h5000_0080, uncached: 1'b0});
    wait_beats(4, 4);
    check("first arid", ar_id_q[0], `CORE_MEM_DATA_ID);
    check("second arid", ar_id_q[1], `CORE_MEM_INST_ID);
    check_line(32'h5000_0080, 4, 1'b1);
    check_line(32'h5000_0040, 4, 1'b0);
  endtask

  task automatic compare_counters();
    repeat (2) @(posedge aclk);
    check("inst_reads", inst_reads, inst_hs);
    check("data_reads", data_reads, data_hs);
    check("data_writes", data_writes, wr_hs);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the DUT stopped answering");
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  initial begin
    seed = 32'h65fd;
    aclk = 1'b0;
    arst_n = 1'b0;
    {inst_rd_valid, data_rd_valid, data_wr_valid} = '0;
    inst_rd_req = '0;
    data_rd_req = '0;
    data_wr_req = '0;
    {arready, wready} = 2'b11;
    {rvalid, rlast, bvalid, awready} = 4'b0001;
    rid = '0;
    rdata = '0;
    {aw_got, w_got, b_pend, aw_stall, ar_stall} = '0;
    rd_left = 0;
    rd_addr = '0;
    rd_id = '0;
    {inst_hs, data_hs, wr_hs, errors} = '0;
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    arst_n = 1'b1;
    read_cached_line();
    read_uncached_word();
    write_then_read_back();
    fill_write_buffer();
    read_priority_order();
    compare_counters();
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/core_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_checker (
  input wire                         aclk,
  input wire                         arst_n_i,
  input wire                         arvalid_i,
  input wire                         arready_i,
  input wire core_mem_pkg::axi_id_t  arid_i,
  input wire core_mem_pkg::addr_t    araddr_i,
  input wire core_mem_pkg::axi_len_t arlen_i,
  input wire                         awvalid_i,
  input wire                         awready_i,
  input wire core_mem_pkg::addr_t    awaddr_i,
  input wire                         wbuf_empty_i,
  input wire                         rvalid_i,
  input wire                         rlast_i,
  input wire                         rready_i
);
  import core_mem_pkg::*;

  logic rd_busy_q;

  // a read is in flight from its AR handshake to its last beat
  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_busy_q <= 1'b0;
    end else if (arvalid_i && arready_i) begin
      rd_busy_q <= 1'b1;
    end else if (rvalid_i && rready_i && rlast_i) begin
      rd_busy_q <= 1'b0;
    end
  end

  // payload held until the slave takes it
  ar_stable: assert property (@(posedge aclk) disable iff (!arst_n_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable({arid_i, araddr_i, arlen_i}))
    else $error("AR payload changed while waiting for arready");

  aw_stable: assert property (@(posedge aclk) disable iff (!arst_n_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("AW payload changed while waiting for awready");

  // single word AR means uncached
  unc_order: assert property (@(posedge aclk) disable iff (!arst_n_i)
    $rose(arvalid_i) && (arlen_i == '0) |-> wbuf_empty_i)
    else $error("uncached read issued with writes still buffered");

  rready_outstanding: assert property (@(posedge aclk) disable iff (!arst_n_i)
    rready_i |-> rd_busy_q)
    else $error("rready high while no read is outstanding");

endmodule

bind core_mem_top core_mem_checker u_checker (
  .aclk         (aclk),
  .arst_n_i     (arst_n_i),
  .arvalid_i    (arvalid_o),
  .arready_i    (arready_i),
  .arid_i       (arid_o),
  .araddr_i     (araddr_o),
  .arlen_i      (arlen_o),
  .awvalid_i    (awvalid_o),
  .awready_i    (awready_i),
  .awaddr_i     (awaddr_o),
  .wbuf_empty_i (wbuf_empty),
  .rvalid_i     (rvalid_i),
  .rlast_i      (rlast_i),
  .rready_i     (rready_o)
);

`default_nettype wire

//--- logic/core_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_top (
  input  wire                        aclk,
  input  wire                        arst_n_i,
  // instruction read port
  input  wire                        inst_rd_valid_i,
  input  wire core_mem_pkg::rd_req_t inst_rd_req_i,
  output logic                       inst_rd_ready_o,
  output logic                       inst_ret_valid_o,
  output core_mem_pkg::rd_ret_t      inst_ret_o,
  // data read port
  input  wire                        data_rd_valid_i,
  input  wire core_mem_pkg::rd_req_t data_rd_req_i,
  output logic                       data_rd_ready_o,
  output logic                       data_ret_valid_o,
  output core_mem_pkg::rd_ret_t      data_ret_o,
  // data write port
  input  wire                        data_wr_valid_i,
  input  wire core_mem_pkg::wr_req_t data_wr_req_i,
  output logic                       data_wr_ready_o,
  // axi read
  output core_mem_pkg::axi_id_t      arid_o,
  output core_mem_pkg::addr_t        araddr_o,
  output core_mem_pkg::axi_len_t     arlen_o,
  output logic [2:0]                 arsize_o,
  output logic [1:0]                 arburst_o,
  output logic                       arvalid_o,
  input  wire                        arready_i,
  input  wire core_mem_pkg::axi_id_t rid_i,
  input  wire core_mem_pkg::data_t   rdata_i,
  input  wire                        rlast_i,
  input  wire                        rvalid_i,
  output logic                       rready_o,
  // axi write
  output core_mem_pkg::axi_id_t      awid_o,
  output core_mem_pkg::addr_t        awaddr_o,
  output core_mem_pkg::axi_len_t     awlen_o,
  output logic [2:0]                 awsize_o,
  output logic [1:0]                 awburst_o,
  output logic                       awvalid_o,
  input  wire                        awready_i,
  output core_mem_pkg::data_t        wdata_o,
  output core_mem_pkg::strb_t        wstrb_o,
  output logic                       wlast_o,
  output logic                       wvalid_o,
  input  wire                        wready_i,
  input  wire                        bvalid_i,
  output logic                       bready_o,
  // event counters
  output core_mem_pkg::perf_cnt_t    inst_reads_o,
  output core_mem_pkg::perf_cnt_t    data_reads_o,
  output core_mem_pkg::perf_cnt_t    data_writes_o,
  output core_mem_pkg::perf_cnt_t    unc_stalls_o
);
  import core_mem_pkg::*;

  logic    wbuf_empty;
  logic    inst_acc;
  logic    data_rd_acc;
  logic    unc_stall;
  logic    wr_acc;
  rd_ret_t ret;

  // one return bus, qualified per port by its valid
  assign inst_ret_o = ret;
  assign data_ret_o = ret;

  axi_read_arbiter u_rd_arb (
    .aclk             (aclk),
    .arst_n_i         (arst_n_i),
    .inst_rd_valid_i  (inst_rd_valid_i),
    .inst_rd_req_i    (inst_rd_req_i),
    .inst_rd_ready_o  (inst_rd_ready_o),
    .inst_ret_valid_o (inst_ret_valid_o),
    .data_rd_valid_i  (data_rd_valid_i),
    .data_rd_req_i    (data_rd_req_i),
    .data_rd_ready_o  (data_rd_ready_o),
    .data_ret_valid_o (data_ret_valid_o),
    .ret_o            (ret),
    .wbuf_empty_i     (wbuf_empty),
    .arid_o           (arid_o),
    .araddr_o         (araddr_o),
    .arlen_o          (arlen_o),
    .arsize_o         (arsize_o),
    .arburst_o        (arburst_o),
    .arvalid_o        (arvalid_o),
    .arready_i        (arready_i),
    .rid_i            (rid_i),
    .rdata_i          (rdata_i),
    .rlast_i          (rlast_i),
    .rvalid_i         (rvalid_i),
    .rready_o         (rready_o),
    .inst_acc_o       (inst_acc),
    .data_rd_acc_o    (data_rd_acc),
    .unc_stall_o      (unc_stall)
  );

  axi_write_buffer u_wbuf (
    .aclk         (aclk),
    .arst_n_i     (arst_n_i),
    .wr_valid_i   (data_wr_valid_i),
    .wr_req_i     (data_wr_req_i),
    .wr_ready_o   (data_wr_ready_o),
    .awid_o       (awid_o),
    .awaddr_o     (awaddr_o),
    .awlen_o      (awlen_o),
    .awsize_o     (awsize_o),
    .awburst_o    (awburst_o),
    .awvalid_o    (awvalid_o),
    .awready_i    (awready_i),
    .wdata_o      (wdata_o),
    .wstrb_o      (wstrb_o),
    .wlast_o      (wlast_o),
    .wvalid_o     (wvalid_o),
    .wready_i     (wready_i),
    .bvalid_i     (bvalid_i),
    .bready_o     (bready_o),
    .wbuf_empty_o (wbuf_empty),
    .wr_acc_o     (wr_acc)
  );

  perf_counters u_perf (
    .aclk          (aclk),
    .arst_n_i      (arst_n_i),
    .inst_acc_i    (inst_acc),
    .data_rd_acc_i (data_rd_acc),
    .wr_acc_i      (wr_acc),
    .unc_stall_i   (unc_stall),
    .inst_reads_o  (inst_reads_o),
    .data_reads_o  (data_reads_o),
    .data_writes_o (data_writes_o),
    .unc_stalls_o  (unc_stalls_o)
  );

endmodule

`default_nettype wire

//--- logic/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
  input  wire                     aclk,
  input  wire                     arst_n_i,
  input  wire                     inst_acc_i,
  input  wire                     data_rd_acc_i,
  input  wire                     wr_acc_i,
  input  wire                     unc_stall_i,
  output core_mem_pkg::perf_cnt_t inst_reads_o,
  output core_mem_pkg::perf_cnt_t data_reads_o,
  output core_mem_pkg::perf_cnt_t data_writes_o,
  output core_mem_pkg::perf_cnt_t unc_stalls_o
);
  import core_mem_pkg::*;

  localparam int N_EV = 4;

  logic [N_EV-1:0] ev;
  perf_cnt_t       cnt_q [N_EV];

  assign ev = {unc_stall_i, wr_acc_i, data_rd_acc_i, inst_acc_i};

  // counters stick at all ones
  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < N_EV; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_EV; i++) begin
        if (ev[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign inst_reads_o  = cnt_q[0];
  assign data_reads_o  = cnt_q[1];
  assign data_writes_o = cnt_q[2];
  assign unc_stalls_o  = cnt_q[3];

endmodule

`default_nettype wire

//--- logic/axi_write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_mem_defines.svh"

module axi_write_buffer (
  input  wire                        aclk,
  input  wire                        arst_n_i,
  input  wire                        wr_valid_i,
  input  wire core_mem_pkg::wr_req_t wr_req_i,
  output logic                       wr_ready_o,
  // axi write address
  output core_mem_pkg::axi_id_t      awid_o,
  output core_mem_pkg::addr_t        awaddr_o,
  output core_mem_pkg::axi_len_t     awlen_o,
  output logic [2:0]                 awsize_o,
  output logic [1:0]                 awburst_o,
  output logic                       awvalid_o,
  input  wire                        awready_i,
  // axi write data
  output core_mem_pkg::data_t        wdata_o,
  output core_mem_pkg::strb_t        wstrb_o,
  output logic                       wlast_o,
  output logic                       wvalid_o,
  input  wire                        wready_i,
  // axi write response
  input  wire                        bvalid_i,
  output logic                       bready_o,
  output logic                       wbuf_empty_o,
  output logic                       wr_acc_o
);
  import core_mem_pkg::*;

  localparam int DEPTH = `CORE_MEM_WBUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  wr_req_t          mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_next;
  wr_state_e        state_q;
  logic             aw_done_q;
  logic             w_done_q;
  logic             empty_q;
  logic             push;
  logic             pop;
  logic             aw_hs;
  logic             w_hs;
  wr_req_t          head;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_ready_o = (count_q != CNT_W'(DEPTH));
  assign push       = wr_valid_i && wr_ready_o;
  assign wr_acc_o   = push;

  // entry leaves only once its response is back
  assign pop   = (state_q == WR_RESP) && bvalid_i;
  assign aw_hs = awvalid_o && awready_i;
  assign w_hs  = wvalid_o && wready_i;

  always_comb begin
    count_next = count_q;
    if (push && !pop) begin
      count_next = count_q + 1'b1;
    end else if (pop && !push) begin
      count_next = count_q - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_req_i;
    end
  end

  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      empty_q  <= 1'b1;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_next;
      empty_q <= (count_next == '0);
    end
  end

  // aw and w may complete in either order
  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= WR_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (count_q != '0) begin
            state_q <= WR_ADDR_DATA;
          end
        end
        WR_ADDR_DATA: begin
          if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
            state_q   <= WR_RESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end else begin
            aw_done_q <= aw_done_q || aw_hs;
            w_done_q  <= w_done_q || w_hs;
          end
        end
        WR_RESP: begin
          if (bvalid_i) begin
            state_q <= WR_IDLE;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  assign head = mem_q[rd_ptr_q];

  assign awid_o    = axi_id_t'(`CORE_MEM_DATA_ID);
  assign awaddr_o  = head.addr;
  assign awlen_o   = '0;
  assign awsize_o  = 3'd2;
  assign awburst_o = 2'b01;
  assign awvalid_o = (state_q == WR_ADDR_DATA) && !aw_done_q;
  assign wdata_o   = head.data;
  assign wstrb_o   = head.strb;
  assign wlast_o   = 1'b1;
  assign wvalid_o  = (state_q == WR_ADDR_DATA) && !w_done_q;
  assign bready_o  = (state_q == WR_RESP);

  assign wbuf_empty_o = empty_q;

endmodule

`default_nettype wire

//--- logic/axi_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_mem_defines.svh"

module axi_read_arbiter (
  input  wire                        aclk,
  input  wire                        arst_n_i,
  // instruction read port
  input  wire                        inst_rd_valid_i,
  input  wire core_mem_pkg::rd_req_t inst_rd_req_i,
  output logic                       inst_rd_ready_o,
  output logic                       inst_ret_valid_o,
  // data read port
  input  wire                        data_rd_valid_i,
  input  wire core_mem_pkg::rd_req_t data_rd_req_i,
  output logic                       data_rd_ready_o,
  output logic                       data_ret_valid_o,
  output core_mem_pkg::rd_ret_t      ret_o,
  input  wire                        wbuf_empty_i,
  // axi read address
  output core_mem_pkg::axi_id_t      arid_o,
  output core_mem_pkg::addr_t        araddr_o,
  output core_mem_pkg::axi_len_t     arlen_o,
  output logic [2:0]                 arsize_o,
  output logic [1:0]                 arburst_o,
  output logic                       arvalid_o,
  input  wire                        arready_i,
  // axi read data
  input  wire core_mem_pkg::axi_id_t rid_i,
  input  wire core_mem_pkg::data_t   rdata_i,
  input  wire                        rlast_i,
  input  wire                        rvalid_i,
  output logic                       rready_o,
  // event pulses
  output logic                       inst_acc_o,
  output logic                       data_rd_acc_o,
  output logic                       unc_stall_o
);
  import core_mem_pkg::*;

  localparam int LINE_BYTES = `CORE_MEM_LINE_BEATS * (`CORE_MEM_DATA_W / 8);
  localparam addr_t LINE_MASK = ~addr_t'(LINE_BYTES - 1);

  rd_state_e state_q;
  rd_req_t   req_q;
  axi_id_t   id_q;

  logic idle;
  logic inst_ok;
  logic data_ok;
  logic data_elig;
  logic inst_take;
  logic data_take;

  assign idle = (state_q == RD_IDLE);

  // an uncached read may not pass a posted write
  assign inst_ok = !inst_rd_req_i.uncached || wbuf_empty_i;
  assign data_ok = !data_rd_req_i.uncached || wbuf_empty_i;

  // data side wins a tie
  assign data_elig       = data_rd_valid_i && data_ok;
  assign data_rd_ready_o = idle && data_ok;
  assign inst_rd_ready_o = idle && inst_ok && !data_elig;

  assign data_take = data_rd_valid_i && data_rd_ready_o;
  assign inst_take = inst_rd_valid_i && inst_rd_ready_o;

  assign data_rd_acc_o = data_take;
  assign inst_acc_o    = inst_take;

  // only the write buffer holds these back
  assign unc_stall_o = idle &&
                       ((data_rd_valid_i && !data_ok) ||
                        (inst_rd_valid_i && !inst_ok && !data_elig));

  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (data_take || inst_take) begin
            state_q <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (arready_i) begin
            state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (rvalid_i && rlast_i) begin
            state_q <= RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (data_take) begin
      req_q <= data_rd_req_i;
      id_q  <= axi_id_t'(`CORE_MEM_DATA_ID);
    end else if (inst_take) begin
      req_q <= inst_rd_req_i;
      id_q  <= axi_id_t'(`CORE_MEM_INST_ID);
    end
  end

  assign arid_o    = id_q;
  assign araddr_o  = req_q.uncached ? req_q.addr : (req_q.addr & LINE_MASK);
  assign arlen_o   = req_q.uncached ? axi_len_t'(0) : axi_len_t'(`CORE_MEM_LINE_BEATS - 1);
  assign arsize_o  = 3'd2;
  assign arburst_o = 2'b01;
  assign arvalid_o = (state_q == RD_ADDR);
  assign rready_o  = (state_q == RD_DATA);

  // steer each beat by its id
  assign inst_ret_valid_o = rready_o && rvalid_i &&
                            (rid_i == axi_id_t'(`CORE_MEM_INST_ID));
  assign data_ret_valid_o = rready_o && rvalid_i &&
                            (rid_i == axi_id_t'(`CORE_MEM_DATA_ID));
  assign ret_o = '{data: rdata_i, last: rlast_i};

endmodule

`default_nettype wire

//--- logic/core_mem_pkg.sv
`default_nettype none

`include "core_mem_defines.svh"

package core_mem_pkg;

  typedef logic [`CORE_MEM_ADDR_W-1:0] addr_t;
  typedef logic [`CORE_MEM_DATA_W-1:0] data_t;
  typedef logic [`CORE_MEM_STRB_W-1:0] strb_t;
  typedef logic [`CORE_MEM_ID_W-1:0]   axi_id_t;
  typedef logic [7:0]                  axi_len_t;
  typedef logic [`CORE_MEM_PERF_W-1:0] perf_cnt_t;

  // read request from either cache port
  typedef struct packed {
    addr_t addr;
    logic  uncached;
  } rd_req_t;

  // single word posted write
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wr_req_t;

  // one beat handed back to the requester
  typedef struct packed {
    data_t data;
    logic  last;
  } rd_ret_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR_DATA,
    WR_RESP
  } wr_state_e;

endpackage

`default_nettype wire

//--- include/core_mem_defines.svh
`ifndef CORE_MEM_DEFINES_SVH
`define CORE_MEM_DEFINES_SVH

// bus widths
`define CORE_MEM_ADDR_W 32
`define CORE_MEM_DATA_W 32
`define CORE_MEM_STRB_W 4

// axi ids, instruction and data side
`define CORE_MEM_ID_W 4
`define CORE_MEM_INST_ID 0
`define CORE_MEM_DATA_ID 1

// words per cache line, fetched as one incr burst
`define CORE_MEM_LINE_BEATS 4

// posted write entries
`define CORE_MEM_WBUF_DEPTH 4

// event counter width
`define CORE_MEM_PERF_W 32

`endif
